/* src/periph_bus_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral bus types: data byte, system address and interrupt sources
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package periph_bus_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;

    // one bit per interrupt source
    typedef logic [3:0]  int_src_t;

    localparam int unsigned src_gpio  = 0;
    localparam int unsigned src_timer = 1;
    localparam int unsigned src_soft  = 2;

    // bit 3 is reserved and always zero
    localparam int_src_t src_valid = 4'b0111;

endpackage

/* src/periph_map_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral memory map: register counts, block offsets and the local
// offset type seen by every block behind the address window
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package periph_map_pkg;

    // registers per block
    localparam int unsigned exti_size  = 3;
    localparam int unsigned gpio_size  = 6;
    localparam int unsigned timer_size = 3;
    localparam int unsigned power_size = 2;

    // blocks are packed back to back
    localparam int unsigned exti_off  = 0;
    localparam int unsigned gpio_off  = exti_off + exti_size;
    localparam int unsigned timer_off = gpio_off + gpio_size;
    localparam int unsigned power_off = timer_off + timer_size;

    localparam int unsigned total_size   = power_off + power_size;
    localparam int unsigned offset_width = $clog2(total_size);

    typedef logic [offset_width-1:0] offset_t;

    // true when offset lies in [base, base + size)
    function automatic logic block_hit(offset_t offset, int unsigned base,
                                       int unsigned size);
        return (offset >= base) && (offset < base + size);
    endfunction

endpackage

/* src/periph_bus_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded peripheral access, shared by all blocks behind the window
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface periph_bus_if;
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    // access inside the window
    logic    sel;
    // address relative to the window base
    offset_t offset;
    byte_t   wdata;
    logic    we;

    modport bus (
        output sel, offset, wdata, we
    );

    modport target (
        input sel, offset, wdata, we
    );

endinterface

/* src/periph_exti.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// External interrupt controller: pending flags, mask and software trigger
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module periph_exti (
    input  logic                     clk,
    input  logic                     rst,
    periph_bus_if.target             bus,
    output periph_bus_pkg::byte_t    rdata,
    input  logic                     gpio_irq,
    input  logic                     timer_irq,
    output periph_bus_pkg::int_src_t cpu_int
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    int_src_t mask;
    int_src_t pending;
    int_src_t src_set;
    int_src_t src_clr;
    logic     hit;
    logic     wr;
    offset_t  idx;

    assign hit = bus.sel && block_hit(bus.offset, exti_off, exti_size);
    assign idx = bus.offset - offset_t'(exti_off);
    assign wr  = hit && bus.we;

    always_comb
    begin
        src_set = '0;
        src_set[src_gpio]  = gpio_irq;
        src_set[src_timer] = timer_irq;
        // software trigger, register 2
        src_set[src_soft]  = wr && (idx == 2) && bus.wdata[0];
    end

    // write one to clear
    assign src_clr = (wr && idx == 1) ? int_src_t'(bus.wdata[3:0]) : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mask    <= '0;
            pending <= '0;
        end
        else
        begin
            // a new pulse wins over a clear in the same cycle
            pending <= ((pending & ~src_clr) | src_set) & src_valid;
            if (wr && idx == 0)
                mask <= int_src_t'(bus.wdata[3:0]) & src_valid;
        end
    end

    assign cpu_int = pending & mask;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0:       rdata = byte_t'(mask);
                1:       rdata = byte_t'(pending);
                default: rdata = '0;
            endcase
        end
    end

endmodule

/* src/periph_gpio.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO port: synchronized inputs, output latches and rising-edge interrupt
// with a per-bit edge enable
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module periph_gpio #(
    parameter int gpio_width = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    periph_bus_if.target          bus,
    output periph_bus_pkg::byte_t rdata,
    input  logic [gpio_width-1:0] gpi,
    output logic [gpio_width-1:0] gpo,
    output logic                  irq
);
    import periph_map_pkg::*;

    logic [gpio_width-1:0] gpi_meta;
    logic [gpio_width-1:0] gpi_sync;
    logic [gpio_width-1:0] gpi_prev;
    logic [gpio_width-1:0] edge_en;
    logic [15:0]           in_word;
    logic [15:0]           out_word;
    logic [15:0]           en_word;
    logic                  hit;
    logic                  wr;
    offset_t               idx;

    assign hit = bus.sel && block_hit(bus.offset, gpio_off, gpio_size);
    assign idx = bus.offset - offset_t'(gpio_off);
    assign wr  = hit && bus.we;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            gpi_meta <= '0;
            gpi_sync <= '0;
            gpi_prev <= '0;
            gpo      <= '0;
            edge_en  <= '0;
        end
        else
        begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
            gpi_prev <= gpi_sync;
            // only the bytes that exist take writes
            if (wr)
            begin
                for (int b = 0; b < gpio_width / 8; b++)
                begin
                    if (idx == offset_t'(2 + b))
                        gpo[b*8 +: 8] <= bus.wdata;
                    if (idx == offset_t'(4 + b))
                        edge_en[b*8 +: 8] <= bus.wdata;
                end
            end
        end
    end

    assign irq = |(gpi_sync & ~gpi_prev & edge_en);

    // missing high byte reads as zero
    assign in_word  = 16'(gpi_sync);
    assign out_word = 16'(gpo);
    assign en_word  = 16'(edge_en);

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0:       rdata = in_word[7:0];
                1:       rdata = in_word[15:8];
                2:       rdata = out_word[7:0];
                3:       rdata = out_word[15:8];
                4:       rdata = en_word[7:0];
                5:       rdata = en_word[15:8];
                default: rdata = '0;
            endcase
        end
    end

endmodule

/* src/periph_timer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reload timer: 16-bit down-counter, one irq pulse per expiry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module periph_timer (
    input  logic                  clk,
    input  logic                  rst,
    periph_bus_if.target          bus,
    output periph_bus_pkg::byte_t rdata,
    output logic                  irq
);
    import periph_map_pkg::*;

    logic        run;
    logic [15:0] reload;
    logic [15:0] count;
    logic        hit;
    logic        wr;
    offset_t     idx;

    assign hit = bus.sel && block_hit(bus.offset, timer_off, timer_size);
    assign idx = bus.offset - offset_t'(timer_off);
    assign wr  = hit && bus.we;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run    <= 1'b0;
            reload <= '0;
            count  <= '0;
            irq    <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            if (wr && idx == 0)
            begin
                run <= bus.wdata[0];
                // starting the timer restarts the count
                if (bus.wdata[0])
                    count <= reload;
            end
            else if (run)
            begin
                if (count == '0)
                begin
                    count <= reload;
                    irq   <= 1'b1;
                end
                else
                begin
                    count <= count - 16'd1;
                end
            end

            if (wr && idx == 1)
                reload[7:0] <= bus.wdata;
            if (wr && idx == 2)
                reload[15:8] <= bus.wdata;
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0:       rdata = {7'd0, run};
                1:       rdata = reload[7:0];
                2:       rdata = reload[15:8];
                default: rdata = '0;
            endcase
        end
    end

endmodule

/* src/periph_power.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Power manager: stalls the CPU on a sleep write, wakes on masked interrupts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module periph_power (
    input  logic                     clk,
    input  logic                     rst,
    periph_bus_if.target             bus,
    output periph_bus_pkg::byte_t    rdata,
    input  periph_bus_pkg::int_src_t cpu_int,
    output logic                     cpu_enable
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    logic     asleep;
    int_src_t wake_mask;
    logic     wake;
    logic     hit;
    logic     wr;
    offset_t  idx;

    assign hit  = bus.sel && block_hit(bus.offset, power_off, power_size);
    assign idx  = bus.offset - offset_t'(power_off);
    assign wr   = hit && bus.we;
    assign wake = |(cpu_int & wake_mask);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            asleep    <= 1'b0;
            wake_mask <= '0;
        end
        else
        begin
            // a pending wake source overrides any sleep request
            if (wake)
                asleep <= 1'b0;
            else if (wr && idx == 0)
                asleep <= bus.wdata[0];
            if (wr && idx == 1)
                wake_mask <= int_src_t'(bus.wdata[3:0]);
        end
    end

    assign cpu_enable = ~asleep;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0:       rdata = {7'd0, asleep};
                1:       rdata = byte_t'(wake_mask);
                default: rdata = '0;
            endcase
        end
    end

endmodule

/* src/reflet_peripheral.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral subsystem of the microcontroller: decodes the register window
// above base_addr and joins exti, GPIO, timer and power manager
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module reflet_peripheral #(
    parameter periph_bus_pkg::addr_t base_addr  = 16'hFF00,
    parameter int                    gpio_width = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  periph_bus_pkg::addr_t    addr,
    input  periph_bus_pkg::byte_t    data_in,
    output periph_bus_pkg::byte_t    data_out,
    input  logic                     write_en,
    input  logic [gpio_width-1:0]    gpi,
    output logic [gpio_width-1:0]    gpo,
    output periph_bus_pkg::int_src_t ext_int,
    output logic                     cpu_enable
);
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    addr_t addr_diff;
    logic  in_window;
    byte_t dout_exti;
    byte_t dout_gpio;
    byte_t dout_timer;
    byte_t dout_power;
    logic  gpio_irq;
    logic  timer_irq;

    periph_bus_if periph_bus ();

    // distance from base, no wrap past the top of memory
    assign addr_diff = addr - base_addr;
    assign in_window = enable && (addr >= base_addr) && (addr_diff < addr_t'(total_size));

    assign periph_bus.sel    = in_window;
    assign periph_bus.offset = offset_t'(addr_diff);
    assign periph_bus.wdata  = data_in;
    assign periph_bus.we     = write_en;

    periph_exti exti_inst (
        .clk       (clk),
        .rst       (rst),
        .bus       (periph_bus),
        .rdata     (dout_exti),
        .gpio_irq  (gpio_irq),
        .timer_irq (timer_irq),
        .cpu_int   (ext_int)
    );

    periph_gpio #(
        .gpio_width (gpio_width)
    ) gpio_inst (
        .clk   (clk),
        .rst   (rst),
        .bus   (periph_bus),
        .rdata (dout_gpio),
        .gpi   (gpi),
        .gpo   (gpo),
        .irq   (gpio_irq)
    );

    periph_timer timer_inst (
        .clk   (clk),
        .rst   (rst),
        .bus   (periph_bus),
        .rdata (dout_timer),
        .irq   (timer_irq)
    );

    periph_power power_inst (
        .clk        (clk),
        .rst        (rst),
        .bus        (periph_bus),
        .rdata      (dout_power),
        .cpu_int    (ext_int),
        .cpu_enable (cpu_enable)
    );

    // unaddressed blocks drive zero
    assign data_out = dout_exti | dout_gpio | dout_timer | dout_power;

endmodule

/* dv/tb_reflet_peripheral.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the peripheral subsystem covering decode, GPIO,
// timer, interrupt controller and power manager over the byte bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_reflet_peripheral;
    timeunit 1ns;
    timeprecision 100ps;
    import periph_bus_pkg::*;
    import periph_map_pkg::*;

    localparam addr_t base_addr    = 16'hFF00;
    localparam int    clk_period   = 4;
    localparam int    reset_cycles = 16;
    // rough cycle count of each test in run order
    localparam int    run_cycles   = reset_cycles + 16 + 20 + 50 + 130 + 20 + 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        enable;
    addr_t       addr;
    byte_t       data_in;
    byte_t       data_out;
    logic        write_en;
    logic [15:0] gpi;
    logic [15:0] gpo;
    int_src_t    ext_int;
    logic        cpu_enable;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          mark;

    reflet_peripheral reflet_peripheral_inst (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .addr       (addr),
        .data_in    (data_in),
        .data_out   (data_out),
        .write_en   (write_en),
        .gpi        (gpi),
        .gpo        (gpo),
        .ext_int    (ext_int),
        .cpu_enable (cpu_enable)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_byte(string name, byte_t exp, byte_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0.1f ns: %s expected %02h, got %02h",
                     $realtime, name, exp, got);
        end
    endtask

    task automatic check_int(string name, int_src_t exp, int_src_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0.1f ns: %s expected %04b, got %04b",
                     $realtime, name, exp, got);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0.1f ns: %s expected %b, got %b",
                     $realtime, name, exp, got);
        end
    endtask

    task automatic note_failure(string msg);
        errors++;
        $display("at %0.1f ns: %s", $realtime, msg);
    endtask

    task automatic tick(int n);
        repeat (n) @(posedge clk);
    endtask

    // inputs change just after the rising edge
    task automatic drive_bus(logic en, addr_t a, byte_t d, logic we);
        @(posedge clk);
        #0.5;
        enable   = en;
        addr     = a;
        data_in  = d;
        write_en = we;
    endtask

    task automatic set_gpi(logic [15:0] value);
        @(posedge clk);
        #0.5;
        gpi = value;
    endtask

    task automatic bus_write(int unsigned off, byte_t d);
        drive_bus(1'b1, addr_t'(base_addr + off), d, 1'b1);
        drive_bus(1'b0, '0, '0, 1'b0);
    endtask

    // read data is combinational and sampled mid-cycle
    task automatic read_at(logic en, addr_t a, output byte_t d);
        drive_bus(en, a, '0, 1'b0);
        @(negedge clk);
        d = data_out;
        drive_bus(1'b0, '0, '0, 1'b0);
    endtask

    task automatic bus_read(int unsigned off, output byte_t d);
        read_at(1'b1, addr_t'(base_addr + off), d);
    endtask

    task automatic read_check(string name, int unsigned off, byte_t exp);
        byte_t got;
        bus_read(off, got);
        check_byte(name, exp, got);
    endtask

    // cycles counts rising edges from the call until the bit is seen
    task automatic wait_ext_int(int bit_idx, int limit, output logic seen, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (ext_int[bit_idx] !== 1'b1 && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        seen = (ext_int[bit_idx] === 1'b1);
    endtask

    task automatic wait_cpu_wake(int limit, output logic seen);
        int cycles;
        cycles = 0;
        while (cpu_enable !== 1'b1 && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        seen = (cpu_enable === 1'b1);
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %-20s ok", name);
        else
        begin
            tests_failed++;
            $display("test %-20s %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic reset_and_decode();
        byte_t got;
        check_bit("cpu_enable", 1'b1, cpu_enable);
        check_int("ext_int", 4'b0000, ext_int);
        check_byte("gpo[7:0]", 8'h00, gpo[7:0]);
        check_byte("gpo[15:8]", 8'h00, gpo[15:8]);
        bus_write(exti_off, 8'h07);
        read_check("exti mask", exti_off, 8'h07);
        read_at(1'b0, addr_t'(base_addr + exti_off), got);
        check_byte("data_out, enable low", 8'h00, got);
        // same low bits as the exti mask register
        read_at(1'b1, addr_t'(base_addr - 16'h0010 + exti_off), got);
        check_byte("data_out below base", 8'h00, got);
        read_at(1'b1, addr_t'(base_addr + total_size), got);
        check_byte("data_out past window", 8'h00, got);
        bus_write(exti_off, 8'h00);
    endtask

    task automatic gpio_registers();
        byte_t       lo;
        byte_t       hi;
        logic [15:0] pattern;
        lo = byte_t'($urandom);
        hi = byte_t'($urandom);
        bus_write(gpio_off + 2, lo);
        bus_write(gpio_off + 3, hi);
        check_byte("gpo[7:0]", lo, gpo[7:0]);
        check_byte("gpo[15:8]", hi, gpo[15:8]);
        read_check("gpio out_lo", gpio_off + 2, lo);
        read_check("gpio out_hi", gpio_off + 3, hi);
        pattern = 16'($urandom);
        set_gpi(pattern);
        // synchronizer delay
        tick(3);
        read_check("gpio in_lo", gpio_off, pattern[7:0]);
        read_check("gpio in_hi", gpio_off + 1, pattern[15:8]);
    endtask

    task automatic gpio_edge_irq();
        int   k;
        int   j;
        int   cycles;
        logic seen;
        k = int'($urandom_range(15, 0));
        j = (k + 1 + int'($urandom_range(14, 0))) % 16;
        set_gpi('0);
        tick(4);
        bus_write(exti_off + 1, 8'h0F);
        bus_write(exti_off, 8'h01);
        bus_write(gpio_off + 4 + k / 8, byte_t'(1 << (k % 8)));
        // edge on a bit without edge enable
        set_gpi(16'h0001 << j);
        tick(6);
        check_int("ext_int, disabled bit", 4'b0000, ext_int);
        set_gpi('0);
        tick(4);
        set_gpi(16'h0001 << k);
        wait_ext_int(0, 8, seen, cycles);
        if (!seen)
            note_failure("gpio edge did not raise ext_int bit 0");
        else if (cycles != 3)
            note_failure($sformatf("gpio interrupt after %0d cycles, expected 3", cycles));
        read_check("exti pending", exti_off + 1, 8'h01);
        bus_write(exti_off + 1, 8'h01);
        check_int("ext_int, cleared", 4'b0000, ext_int);
        set_gpi('0);
        tick(6);
        check_int("ext_int, falling edge", 4'b0000, ext_int);
        bus_write(gpio_off + 4 + k / 8, 8'h00);
        bus_write(exti_off, 8'h00);
    endtask

    task automatic timer_reload();
        int   cycles;
        logic seen;
        bus_write(exti_off + 1, 8'h0F);
        bus_write(exti_off, 8'h02);
        bus_write(timer_off + 1, 8'd20);
        bus_write(timer_off + 2, 8'd0);
        bus_write(timer_off, 8'h01);
        // period is reload + 1 cycles
        wait_ext_int(1, 40, seen, cycles);
        if (!seen)
            note_failure("timer interrupt did not arrive within 40 cycles");
        else if (cycles < 19 || cycles > 23)
            note_failure($sformatf("timer period %0d cycles, expected 21 +/- 2", cycles));
        read_check("timer control", timer_off, 8'h01);
        bus_write(timer_off, 8'h00);
        read_check("timer control", timer_off, 8'h00);
        bus_write(exti_off + 1, 8'h0F);
        tick(63);
        check_int("ext_int, timer stopped", 4'b0000, ext_int);
        read_check("exti pending", exti_off + 1, 8'h00);
        bus_write(exti_off, 8'h00);
    endtask

    task automatic soft_trigger_mask();
        bus_write(exti_off + 1, 8'h0F);
        bus_write(exti_off, 8'h00);
        bus_write(exti_off + 2, byte_t'($urandom) | 8'h01);
        read_check("exti pending", exti_off + 1, 8'h04);
        check_int("ext_int, masked", 4'b0000, ext_int);
        bus_write(exti_off, 8'h04);
        check_int("ext_int, unmasked", 4'b0100, ext_int);
        read_check("exti pending", exti_off + 1, 8'h04);
        bus_write(exti_off, 8'h00);
        check_int("ext_int, masked again", 4'b0000, ext_int);
        read_check("exti pending", exti_off + 1, 8'h04);
        bus_write(exti_off + 1, 8'h04);
        read_check("exti pending", exti_off + 1, 8'h00);
    endtask

    task automatic power_sleep_wake();
        logic seen;
        bus_write(power_off + 1, 8'h00);
        bus_write(power_off, 8'h01);
        check_bit("cpu_enable, asleep", 1'b0, cpu_enable);
        read_check("power sleep", power_off, 8'h01);
        // software interrupt not yet in the wake mask
        bus_write(exti_off, 8'h04);
        bus_write(exti_off + 2, 8'h01);
        tick(4);
        check_int("ext_int", 4'b0100, ext_int);
        check_bit("cpu_enable, unmasked irq", 1'b0, cpu_enable);
        bus_write(power_off + 1, 8'h04);
        wait_cpu_wake(4, seen);
        if (!seen)
            note_failure("cpu_enable did not return after a masked interrupt");
        read_check("power sleep", power_off, 8'h00);
        bus_write(power_off, 8'h01);
        check_bit("cpu_enable, sleep with wake", 1'b1, cpu_enable);
        bus_write(exti_off + 1, 8'h0F);
        bus_write(exti_off, 8'h00);
        bus_write(power_off + 1, 8'h00);
    endtask

    initial
    begin
        void'($urandom(4));
        rst      = 1'b1;
        enable   = 1'b0;
        addr     = '0;
        data_in  = '0;
        write_en = 1'b0;
        gpi      = '0;
        tick(reset_cycles);
        #0.5;
        rst = 1'b0;

        mark = errors;
        reset_and_decode();
        report_test("reset and decode", mark);
        mark = errors;
        gpio_registers();
        report_test("gpio registers", mark);
        mark = errors;
        gpio_edge_irq();
        report_test("gpio edge interrupt", mark);
        mark = errors;
        timer_reload();
        report_test("timer", mark);
        mark = errors;
        soft_trigger_mask();
        report_test("software trigger", mark);
        mark = errors;
        power_sleep_wake();
        report_test("power", mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        #(2 * run_cycles * clk_period);
        $display("watchdog expired after %0d cycles, tests did not finish", 2 * run_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* reflet_peripheral.f */
src/periph_bus_pkg.sv
src/periph_map_pkg.sv
src/periph_bus_if.sv
src/periph_exti.sv
src/periph_gpio.sv
src/periph_timer.sv
src/periph_power.sv
src/reflet_peripheral.sv
dv/tb_reflet_peripheral.sv

/* run_sim.sh */
#!/bin/sh
# build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f reflet_peripheral.f --top-module tb_reflet_peripheral \
    --Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_reflet_peripheral > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
